// File: hdl/rc_pkg.sv
package rc_pkg;

    // field element width for BN254
    localparam int N_BITS = 254;

    typedef logic [N_BITS-1:0] felem_t;

    // x1 sits at index 0
    typedef felem_t [2:0] rc_state_t;

    localparam felem_t PRIME_MODULUS =
        felem_t'(256'h30644e72e131a029b85045b68181585d2833e84879b9709143e1f593f0000001);

    // bricks plus concrete rounds after the first concrete layer
    localparam int N_ROUNDS = 3;

    // one triple per concrete layer
    localparam felem_t ROUND_CONSTANTS [0:11] = '{
        felem_t'(5748013),  felem_t'(8959805),  felem_t'(5322109),
        felem_t'(9833447),  felem_t'(8565022),  felem_t'(7968812),
        felem_t'(15008204), felem_t'(15007603), felem_t'(9832189),
        felem_t'(2114001),  felem_t'(5269258),  felem_t'(11741327)
    };

    typedef enum logic {
        LAYER_CONCRETE,
        LAYER_BRICKS
    } layer_op_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN_CONCRETE,
        RUN_BRICKS,
        FINISH
    } ctrl_state_t;

    // a + b mod p, both operands already reduced
    function automatic felem_t add_mod(input felem_t a, input felem_t b);
        logic [N_BITS:0] sum;
        logic [N_BITS:0] diff;
        sum  = {1'b0, a} + {1'b0, b};
        diff = sum - {1'b0, PRIME_MODULUS};
        add_mod = (sum >= {1'b0, PRIME_MODULUS}) ? diff[N_BITS-1:0] : sum[N_BITS-1:0];
    endfunction

    // sum of three reduced elements is below 3p, so subtract p or 2p at most
    function automatic felem_t add3_mod(input felem_t a, input felem_t b, input felem_t c);
        logic [N_BITS+1:0] sum;
        logic [N_BITS+1:0] p1;
        logic [N_BITS+1:0] p2;
        sum = {2'b00, a} + {2'b00, b} + {2'b00, c};
        p1  = {2'b00, PRIME_MODULUS};
        p2  = {1'b0, PRIME_MODULUS, 1'b0};
        if (sum >= p2)
            add3_mod = felem_t'(sum - p2);
        else if (sum >= p1)
            add3_mod = felem_t'(sum - p1);
        else
            add3_mod = sum[N_BITS-1:0];
    endfunction

endpackage

// File: hdl/layer_if.sv
interface layer_if;
    import rc_pkg::*;

    // start and done are single-cycle strobes
    logic      start;
    rc_state_t in_state;
    rc_state_t round_consts;
    rc_state_t out_state;
    logic      done;

    modport controller (
        output start,
        output in_state,
        output round_consts,
        input  out_state,
        input  done
    );

    modport layer (
        input  start,
        input  in_state,
        input  round_consts,
        output out_state,
        output done
    );

endinterface

// File: hdl/rc_field_mul.sv
module rc_field_mul #(
    parameter int N_BITS = rc_pkg::N_BITS
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  rc_pkg::felem_t a,
    input  rc_pkg::felem_t b,
    output rc_pkg::felem_t product,
    output logic           done
);
    import rc_pkg::*;

    localparam int CNT_W = $clog2(N_BITS + 1);

    logic             busy;
    logic [CNT_W-1:0] bit_cnt;
    felem_t           a_reg;
    felem_t           b_reg;
    felem_t           acc;
    felem_t           acc_dbl;
    felem_t           acc_next;

    // one double-and-add step, MSB of b first
    always_comb begin
        acc_dbl  = add_mod(acc, acc);
        acc_next = b_reg[$bits(felem_t)-1] ? add_mod(acc_dbl, a_reg) : acc_dbl;
    end

    // N_BITS steps, then one cycle to flag the result
    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy    <= 1'b1;
                bit_cnt <= CNT_W'(N_BITS);
            end else if (busy) begin
                if (bit_cnt == '0) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            a_reg <= a;
            b_reg <= b;
            acc   <= '0;
        end else if (busy && bit_cnt != '0) begin
            acc   <= acc_next;
            b_reg <= b_reg << 1;
        end
    end

    assign product = acc;

    a_no_restart: assert property (@(posedge clk) disable iff (reset) start |-> !busy)
        else $error("multiplier started while still busy");

endmodule

// File: hdl/rc_concrete.sv
module rc_concrete (
    input logic    clk,
    input logic    reset,
    layer_if.layer layer
);
    import rc_pkg::*;

    felem_t elem_sum;

    // common term shared by all three outputs
    always_comb begin
        elem_sum = add3_mod(layer.in_state[0], layer.in_state[1], layer.in_state[2]);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            layer.done <= 1'b0;
        end else begin
            layer.done <= layer.start;
        end
    end

    // y_i = sum + x_i + rc_i
    always_ff @(posedge clk) begin
        if (layer.start) begin
            for (int i = 0; i < 3; i++) begin
                layer.out_state[i] <= add_mod(elem_sum,
                                              add_mod(layer.in_state[i], layer.round_consts[i]));
            end
        end
    end

endmodule

// File: hdl/rc_bricks.sv
module rc_bricks #(
    parameter int N_BITS = rc_pkg::N_BITS
) (
    input logic    clk,
    input logic    reset,
    layer_if.layer layer
);
    import rc_pkg::*;

    logic       mul_start;
    logic [2:0] mul_done;
    logic       pass_done;
    logic [2:0] step;
    felem_t     op_a [3];
    felem_t     op_b [3];
    felem_t     mul_prod [3];
    felem_t     x1;
    felem_t     x2;
    felem_t     x3;
    felem_t     lin2;
    felem_t     lin3;
    felem_t     y2_reg;
    felem_t     y3_reg;

    // input state is held stable by the controller until done
    assign x1 = layer.in_state[0];
    assign x2 = layer.in_state[1];
    assign x3 = layer.in_state[2];

    // all three multipliers run in lockstep
    assign pass_done = &mul_done;

    // x1^2 + x1 + 2 and x2^2 + 3*x2 + 4, squares taken from pass 1
    always_comb begin
        lin2 = add_mod(mul_prod[0], add_mod(x1, felem_t'(2)));
        lin3 = add_mod(mul_prod[1], add_mod(add_mod(x2, x2), add_mod(x2, felem_t'(4))));
    end

    for (genvar i = 0; i < 3; i++) begin : g_mul
        rc_field_mul #(
            .N_BITS(N_BITS)
        ) u_mul (
            .clk    (clk),
            .reset  (reset),
            .start  (mul_start),
            .a      (op_a[i]),
            .b      (op_b[i]),
            .product(mul_prod[i]),
            .done   (mul_done[i])
        );
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            step       <= '0;
            mul_start  <= 1'b0;
            layer.done <= 1'b0;
        end else begin
            mul_start  <= 1'b0;
            layer.done <= 1'b0;
            if (layer.start) begin
                step      <= 3'd1;
                mul_start <= 1'b1;
            end else if (pass_done) begin
                if (step == 3'd3) begin
                    step       <= '0;
                    layer.done <= 1'b1;
                end else begin
                    step      <= step + 1'b1;
                    mul_start <= 1'b1;
                end
            end
        end
    end

    // operand and partial-sum registers for each pass
    always_ff @(posedge clk) begin
        if (layer.start) begin
            op_a[0] <= x1;
            op_b[0] <= x1;
            op_a[1] <= x2;
            op_b[1] <= x2;
            op_a[2] <= x3;
            op_b[2] <= x3;
        end else if (pass_done) begin
            case (step)
                3'd1: begin
                    op_a[0] <= mul_prod[0];
                    op_b[0] <= mul_prod[0];
                    op_a[1] <= x2;
                    op_b[1] <= lin2;
                    op_a[2] <= x3;
                    op_b[2] <= lin3;
                end
                3'd2: begin
                    y2_reg  <= mul_prod[1];
                    y3_reg  <= mul_prod[2];
                    // x1^4 * x1 gives x1^5
                    op_a[0] <= mul_prod[0];
                    op_b[0] <= x1;
                end
                3'd3: begin
                    layer.out_state <= {y3_reg, y2_reg, mul_prod[0]};
                end
                default: begin
                end
            endcase
        end
    end

    a_step_range: assert property (@(posedge clk) disable iff (reset) step <= 3'd3)
        else $error("bricks step counter out of range");

endmodule

// File: hdl/rc_controller.sv
module rc_controller #(
    parameter int N_ROUNDS = rc_pkg::N_ROUNDS
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  rc_pkg::rc_state_t in_state,
    output rc_pkg::rc_state_t out_state,
    output logic              busy,
    output logic              done,
    layer_if.controller       concrete,
    layer_if.controller       bricks
);
    import rc_pkg::*;

    localparam int RND_W = $clog2(N_ROUNDS + 1);

    ctrl_state_t      state;
    logic [RND_W-1:0] round_cnt;
    logic             last_round;
    logic             launch;
    layer_op_t        launch_op;
    rc_state_t        state_reg;
    rc_state_t        round_triple;

    assign last_round = (round_cnt == RND_W'(N_ROUNDS));
    assign done       = (state == FINISH);

    // constant triple for the concrete layer of the current round
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            round_triple[i] = ROUND_CONSTANTS[3 * round_cnt + i];
        end
    end

    assign concrete.in_state     = state_reg;
    assign concrete.round_consts = round_triple;
    assign bricks.in_state       = state_reg;
    assign bricks.round_consts   = round_triple;

    // which layer to kick off next, if any
    always_comb begin
        launch    = 1'b0;
        launch_op = LAYER_CONCRETE;
        case (state)
            IDLE, FINISH: launch = start;
            RUN_CONCRETE: begin
                if (concrete.done && !last_round) begin
                    launch    = 1'b1;
                    launch_op = LAYER_BRICKS;
                end
            end
            RUN_BRICKS: launch = bricks.done;
            default: launch = 1'b0;
        endcase
    end

    // busy spans from the accepted start up to the entry into FINISH
    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= IDLE;
            round_cnt      <= '0;
            busy           <= 1'b0;
            concrete.start <= 1'b0;
            bricks.start   <= 1'b0;
            out_state      <= '0;
        end else begin
            concrete.start <= launch && (launch_op == LAYER_CONCRETE);
            bricks.start   <= launch && (launch_op == LAYER_BRICKS);
            case (state)
                IDLE, FINISH: begin
                    if (start) begin
                        state     <= RUN_CONCRETE;
                        round_cnt <= '0;
                        busy      <= 1'b1;
                    end else begin
                        state <= IDLE;
                    end
                end
                RUN_CONCRETE: begin
                    if (concrete.done) begin
                        if (last_round) begin
                            out_state <= concrete.out_state;
                            busy      <= 1'b0;
                            state     <= FINISH;
                        end else begin
                            state <= RUN_BRICKS;
                        end
                    end
                end
                RUN_BRICKS: begin
                    if (bricks.done) begin
                        round_cnt <= round_cnt + 1'b1;
                        state     <= RUN_CONCRETE;
                    end
                end
                default: begin
                    state <= IDLE;
                    busy  <= 1'b0;
                end
            endcase
        end
    end

    // working state is written back after every layer
    always_ff @(posedge clk) begin
        if (launch && (state == IDLE || state == FINISH))
            state_reg <= in_state;
        else if (state == RUN_CONCRETE && concrete.done)
            state_reg <= concrete.out_state;
        else if (state == RUN_BRICKS && bricks.done)
            state_reg <= bricks.out_state;
    end

    a_done_not_busy: assert property (@(posedge clk) disable iff (reset) !(done && busy))
        else $error("done and busy asserted together");

endmodule

// File: hdl/rc_permutation_top.sv
module rc_permutation_top #(
    parameter int N_BITS   = rc_pkg::N_BITS,
    parameter int N_ROUNDS = rc_pkg::N_ROUNDS
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  rc_pkg::felem_t in_x1,
    input  rc_pkg::felem_t in_x2,
    input  rc_pkg::felem_t in_x3,
    output rc_pkg::felem_t out_x1,
    output rc_pkg::felem_t out_x2,
    output rc_pkg::felem_t out_x3,
    output logic           busy,
    output logic           done
);
    import rc_pkg::*;

    rc_state_t in_state;
    rc_state_t out_state;

    layer_if concrete_bus ();
    layer_if bricks_bus ();

    assign in_state = {in_x3, in_x2, in_x1};
    assign out_x1   = out_state[0];
    assign out_x2   = out_state[1];
    assign out_x3   = out_state[2];

    rc_controller #(
        .N_ROUNDS(N_ROUNDS)
    ) u_controller (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .in_state (in_state),
        .out_state(out_state),
        .busy     (busy),
        .done     (done),
        .concrete (concrete_bus.controller),
        .bricks   (bricks_bus.controller)
    );

    rc_concrete u_concrete (
        .clk  (clk),
        .reset(reset),
        .layer(concrete_bus.layer)
    );

    rc_bricks #(
        .N_BITS(N_BITS)
    ) u_bricks (
        .clk  (clk),
        .reset(reset),
        .layer(bricks_bus.layer)
    );

endmodule

// File: verification/rc_checker.sv
module rc_checker (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  rc_pkg::felem_t in_x1,
    input  rc_pkg::felem_t in_x2,
    input  rc_pkg::felem_t in_x3,
    input  rc_pkg::felem_t out_x1,
    input  rc_pkg::felem_t out_x2,
    input  rc_pkg::felem_t out_x3,
    input  logic           busy,
    input  logic           done,
    output int             error_count,
    output int             result_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import rc_pkg::*;

    rc_state_t expected;
    rc_state_t held;
    logic      pending;
    logic      holding;
    logic      done_prev;

    function automatic felem_t addp(input felem_t a, input felem_t b);
        logic [N_BITS:0] s;
        s = ({1'b0, a} + {1'b0, b}) % {1'b0, PRIME_MODULUS};
        return s[N_BITS-1:0];
    endfunction

    // LSB first, doubling the addend each step
    function automatic felem_t mulp(input felem_t a, input felem_t b);
        felem_t r;
        felem_t d;
        r = '0;
        d = a;
        for (int i = 0; i < N_BITS; i++) begin
            if (b[i])
                r = addp(r, d);
            d = addp(d, d);
        end
        return r;
    endfunction

    function automatic rc_state_t concrete_ref(input rc_state_t x, input int k);
        rc_state_t y;
        felem_t    s;
        s = addp(addp(x[0], x[1]), x[2]);
        for (int i = 0; i < 3; i++)
            y[i] = addp(addp(s, x[i]), ROUND_CONSTANTS[3 * k + i]);
        return y;
    endfunction

    function automatic rc_state_t bricks_ref(input rc_state_t x);
        rc_state_t y;
        felem_t    sq1;
        felem_t    sq2;
        sq1  = mulp(x[0], x[0]);
        sq2  = mulp(x[1], x[1]);
        y[0] = mulp(mulp(sq1, sq1), x[0]);
        y[1] = mulp(x[1], addp(addp(sq1, x[0]), felem_t'(2)));
        y[2] = mulp(x[2], addp(addp(sq2, mulp(felem_t'(3), x[1])), felem_t'(4)));
        return y;
    endfunction

    function automatic rc_state_t permute_ref(input felem_t a, input felem_t b, input felem_t c);
        rc_state_t st;
        st = concrete_ref({c, b, a}, 0);
        for (int r = 1; r <= N_ROUNDS; r++)
            st = concrete_ref(bricks_ref(st), r);
        return st;
    endfunction

    task automatic compare_elem(input string name, input felem_t exp, input felem_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
            error_count++;
        end
    endtask

    task automatic fault(input string msg);
        $display("protocol fault at %0t: %s", $time, msg);
        error_count++;
    endtask

    // outputs are sampled at the edge, where they have been stable for a whole cycle
    always @(posedge clk) begin
        if (reset) begin
            error_count  = 0;
            result_count = 0;
            pending      = 1'b0;
            holding      = 1'b1;
            held         = '0;
            done_prev    = 1'b0;
        end else begin
            if (done) begin
                if (done_prev)
                    fault("done stayed high for more than one cycle");
                if (busy)
                    fault("busy was high in the done cycle");
                if (!pending) begin
                    fault("done arrived without an accepted start");
                end else begin
                    compare_elem("out_x1", expected[0], out_x1);
                    compare_elem("out_x2", expected[1], out_x2);
                    compare_elem("out_x3", expected[2], out_x3);
                    result_count++;
                end
                pending = 1'b0;
                holding = 1'b1;
                held    = {out_x3, out_x2, out_x1};
            end else if (holding) begin
                // idle outputs must keep the last result, zero right after reset
                compare_elem("out_x1", held[0], out_x1);
                compare_elem("out_x2", held[1], out_x2);
                compare_elem("out_x3", held[2], out_x3);
                if (busy)
                    fault("busy went high with no accepted start");
            end
            if (start && !busy) begin
                pending  = 1'b1;
                holding  = 1'b0;
                expected = permute_ref(in_x1, in_x2, in_x3);
            end
            done_prev = done;
        end
    end

endmodule

// File: verification/tb_rc_permutation.sv
module tb_rc_permutation;
    timeunit 1ns;
    timeprecision 100ps;
    import rc_pkg::*;

    localparam int TIMEOUT_CYCLES = 6000;
    localparam int N_RANDOM       = 20;

    logic   clk;
    logic   reset;
    logic   start;
    felem_t in_x1;
    felem_t in_x2;
    felem_t in_x3;
    felem_t out_x1;
    felem_t out_x2;
    felem_t out_x3;
    logic   busy;
    logic   done;
    int     check_errors;
    int     results;
    int     seed;
    int     runs;
    int     timeouts;
    int     tb_errors;
    felem_t r1;
    felem_t r2;
    felem_t r3;

    rc_permutation_top #(
        .N_BITS  (N_BITS),
        .N_ROUNDS(N_ROUNDS)
    ) uut (
        .clk(clk), .reset(reset), .start(start),
        .in_x1(in_x1), .in_x2(in_x2), .in_x3(in_x3),
        .out_x1(out_x1), .out_x2(out_x2), .out_x3(out_x3),
        .busy(busy), .done(done)
    );

    rc_checker u_check (
        .clk(clk), .reset(reset), .start(start),
        .in_x1(in_x1), .in_x2(in_x2), .in_x3(in_x3),
        .out_x1(out_x1), .out_x2(out_x2), .out_x3(out_x3),
        .busy(busy), .done(done),
        .error_count(check_errors), .result_count(results)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic finish_run();
        $display("results %0d, checker errors %0d, testbench errors %0d, timeouts %0d",
                 results, check_errors, tb_errors, timeouts);
        if (check_errors == 0 && tb_errors == 0 && timeouts == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    // raw 256 bits cut to 254, one subtraction brings it below p
    task automatic rand_elem(output felem_t v);
        logic [255:0] raw;
        raw = '0;
        for (int k = 0; k < 8; k++)
            raw = {raw[223:0], $random(seed)};
        v = raw[N_BITS-1:0];
        if (v >= PRIME_MODULUS)
            v = v - PRIME_MODULUS;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout: no done within %0d cycles of start", TIMEOUT_CYCLES);
            timeouts++;
            finish_run();
        end
    endtask

    task automatic pulse_start(input felem_t a, input felem_t b, input felem_t c);
        @(posedge clk);
        #2;
        in_x1 = a;
        in_x2 = b;
        in_x3 = c;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic run_one(input felem_t a, input felem_t b, input felem_t c);
        pulse_start(a, b, c);
        runs++;
        wait_done();
    endtask

    initial begin
        reset     = 1'b1;
        start     = 1'b0;
        in_x1     = '0;
        in_x2     = '0;
        in_x3     = '0;
        seed      = 21;
        runs      = 0;
        timeouts  = 0;
        tb_errors = 0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        // outputs after reset are watched by the checker while idle
        idle(4);
        run_one('0, '0, '0);
        idle(3);
        for (int n = 0; n < N_RANDOM; n++) begin
            rand_elem(r1);
            rand_elem(r2);
            rand_elem(r3);
            run_one(r1, r2, r3);
            idle(3);
        end
        run_one(PRIME_MODULUS - 1, PRIME_MODULUS - 2, felem_t'(1));
        idle(3);
        run_one(PRIME_MODULUS - 1, PRIME_MODULUS - 1, PRIME_MODULUS - 1);
        idle(3);
        // second start lands mid-run and must be dropped
        pulse_start(felem_t'(7), felem_t'(11), felem_t'(13));
        runs++;
        idle(5);
        #2;
        in_x1 = PRIME_MODULUS - 5;
        in_x2 = felem_t'(99);
        in_x3 = felem_t'(3);
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        wait_done();
        idle(20);
        if (results != runs) begin
            $display("saw %0d results for %0d accepted starts", results, runs);
            tb_errors++;
        end
        finish_run();
    end

endmodule

// File: flist.f
hdl/rc_pkg.sv
hdl/layer_if.sv
hdl/rc_field_mul.sv
hdl/rc_concrete.sv
hdl/rc_bricks.sv
hdl/rc_controller.sv
hdl/rc_permutation_top.sv
verification/rc_checker.sv
verification/tb_rc_permutation.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rc_permutation
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
